/* all.f */
+incdir+logic
logic/flash_pkg.sv
logic/spi_byte_port.sv
logic/flash_cmd_decode.sv
logic/flash_read_engine.sv
logic/flash_access_log.sv
logic/flash_emulator.sv
bench/flash_tb_assert.sv
bench/flash_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the flash emulator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f all.f --top-module flash_tb -o flash_sim \
	> build.log 2>&1 &&
	./obj_dir/flash_sim > sim.log 2>&1 ||
	echo "build or run ended with an error, see build.log and sim.log"

grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* bench/flash_tb.sv */
// flash emulator testbench
`timescale 1ns/1ps
`default_nettype none

`include "flash_settings.svh"

module flash_tb
	import flash_pkg::*;
();
	localparam int half_period = 4;
	// last bit of a byte stays high long enough for the ram data to arrive
	localparam int last_hold = 16;
	localparam int fast_latency = 3;
	localparam int slow_latency = 80;
	localparam int idle_gap = 100;

	logic clk;
	logic reset;
	logic cs_n;
	logic sclk;
	logic mosi;
	logic miso;
	ram_addr_t ram_addr;
	logic ram_read_enable;
	spi_byte_t ram_read_data;
	logic ram_read_valid;
	logic spi_critical;
	flash_addr_t log_addr;
	log_len_t log_len;
	logic log_strobe;
	flash_err_t errors;

	logic [15:0] lfsr_state;
	int ram_latency;
	int enable_rises;
	logic enable_prev;
	int log_count;
	flash_addr_t logged_addr;
	log_len_t logged_len;
	flash_addr_t test_addr [0:4];
	int test_len [0:4];
	bit fail_reported;
	bit run_done;

	flash_emulator DUT (
		.clk(clk), .reset(reset),
		.cs_n(cs_n), .sclk(sclk), .mosi(mosi), .miso(miso),
		.ram_addr(ram_addr), .ram_read_enable(ram_read_enable),
		.ram_read_data(ram_read_data), .ram_read_valid(ram_read_valid),
		.spi_critical(spi_critical),
		.log_addr(log_addr), .log_len(log_len), .log_strobe(log_strobe),
		.errors(errors)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
			else
				lfsr_state = lfsr_state >> 1;
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// ram contents, xor of the three address bytes
	function automatic spi_byte_t model_data(input flash_addr_t a);
		return a[23:16] ^ a[15:8] ^ a[7:0];
	endfunction

	task automatic stop_on_error();
		fail_reported = 1'b1;
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected === actual)
		else
		begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			stop_on_error();
		end
	endtask

	// n rising edges, then the usual drive offset
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// mode 0, msb first, miso taken just before each rising sclk
	task automatic transfer_byte(input spi_byte_t tx, output spi_byte_t rx);
		for (int i = 7; i >= 0; i--)
		begin
			mosi = tx[i];
			wait_cycles(half_period);
			rx[i] = miso;
			sclk = 1'b1;
			wait_cycles(i == 0 ? last_hold : half_period);
			sclk = 1'b0;
		end
	endtask

	// opcode, three address bytes, then n data slots
	task automatic run_command(input string name, input spi_byte_t opcode,
		input flash_addr_t addr, input int n, input bit check_data);
		spi_byte_t got;
		log_count = 0;
		enable_rises = 0;
		cs_n = 1'b0;
		wait_cycles(half_period);
		transfer_byte(opcode, got);
		transfer_byte(addr[23:16], got);
		transfer_byte(addr[15:8], got);
		transfer_byte(addr[7:0], got);
		for (int i = 0; i < n; i++)
		begin
			transfer_byte(8'h00, got);
			if (opcode == `FLASH_OP_READ)
				check_value({name, " spi_critical"}, 32'd1, 32'(spi_critical));
			if (check_data)
				check_value({name, " data"}, 32'(model_data(addr + flash_addr_t'(i))),
					32'(got));
		end
		wait_cycles(8);
		cs_n = 1'b1;
		wait_cycles(idle_gap);
		check_value({name, " spi_critical after deselect"}, 32'd0, 32'(spi_critical));
	endtask

	task automatic check_log(input string name, input flash_addr_t addr, input int n);
		check_value({name, " log strobes"}, 32'd1, 32'(log_count));
		check_value({name, " log_addr"}, 32'(addr), 32'(logged_addr));
		check_value({name, " log_len"}, 32'(n), 32'(logged_len));
	endtask

	// ram model, one answer per enable
	initial
	begin
		flash_addr_t req_addr;
		int lat;
		forever
		begin
			@(posedge clk);
			#1;
			if (ram_read_enable)
			begin
				req_addr = ram_addr[23:0];
				lat = ram_latency;
				repeat (lat) @(posedge clk);
				#2;
				ram_read_data = model_data(req_addr);
				ram_read_valid = 1'b1;
				@(posedge clk);
				#2;
				ram_read_valid = 1'b0;
			end
		end
	end

	// counts enables and log records
	initial
	begin
		enable_prev = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			if (ram_read_enable === 1'b1 && !enable_prev)
				enable_rises++;
			enable_prev = (ram_read_enable === 1'b1);
			if (log_strobe === 1'b1)
			begin
				log_count++;
				logged_addr = log_addr;
				logged_len = log_len;
			end
		end
	end

	initial
	begin
		int total_bytes;
		int limit;
		reset = 1'b1;
		cs_n = 1'b1;
		sclk = 1'b0;
		mosi = 1'b0;
		ram_read_data = 8'h00;
		ram_read_valid = 1'b0;
		ram_latency = fast_latency;
		lfsr_state = 16'd83;
		log_count = 0;
		enable_rises = 0;
		fail_reported = 1'b0;
		run_done = 1'b0;

		// reads 0 to 2 and 4 are normal, read 3 meets the slow ram
		total_bytes = 6;
		for (int i = 0; i < 5; i++)
		begin
			test_addr[i] = flash_addr_t'(random_bits(24));
			if (i == 3)
				test_len[i] = 2 + int'(random_bits(2));
			else
				test_len[i] = 1 + int'(random_bits(3));
			total_bytes += 4 + test_len[i];
		end
		limit = total_bytes * 64 + 6 * 400 + 1000;

		fork
			begin
				repeat (limit) @(posedge clk);
				fail_reported = 1'b1;
				$display("timeout, run did not finish within %0d clock cycles", limit);
				$display("Simulation failed");
				$fatal(1, "watchdog expired");
			end
		join_none

		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		wait_cycles(10);

		for (int i = 0; i < 3; i++)
		begin
			run_command("read", `FLASH_OP_READ, test_addr[i], test_len[i], 1'b1);
			check_log("read", test_addr[i], test_len[i]);
		end
		check_value("errors after reads", 32'd0, 32'(errors));

		// unknown opcode is ignored until deselect
		run_command("bad_opcode", 8'h9F, test_addr[0], 2, 1'b0);
		check_value("bad_opcode enables", 32'd0, 32'(enable_rises));
		check_value("bad_opcode log strobes", 32'd0, 32'(log_count));
		check_value("bad_opcode error bit", 32'd1, 32'(errors[err_bad_opcode_bit]));

		ram_latency = slow_latency;
		run_command("slow_read", `FLASH_OP_READ, test_addr[3], test_len[3], 1'b0);
		check_value("slow_read overrun bit", 32'd1, 32'(errors[err_overrun_bit]));
		ram_latency = fast_latency;

		run_command("read_after_overrun", `FLASH_OP_READ, test_addr[4], test_len[4], 1'b1);
		check_log("read_after_overrun", test_addr[4], test_len[4]);
		check_value("overrun bit kept", 32'd1, 32'(errors[err_overrun_bit]));

		run_done = 1'b1;
		if (!fail_reported)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// a bound assertion can also end the run
	final
	begin
		if (!run_done && !fail_reported)
			$display("Simulation failed");
	end
endmodule

`default_nettype wire

/* bench/flash_tb_assert.sv */
// flash emulator assertions
`timescale 1ns/1ps
`default_nettype none

`include "flash_settings.svh"

module flash_tb_assert
	import flash_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic ram_read_enable,
	input wire logic spi_critical,
	input wire logic log_strobe,
	input wire logic cs_n,
	input wire flash_err_t errors
);
	// deselect passes the synchronizer, the edge detect and the engine flop
	localparam int release_cycles = `FLASH_SYNC_STAGES + 2;

	// ram is only read while the bus is locked
	assert property (@(posedge clk) disable iff (reset)
		ram_read_enable |-> spi_critical)
		else $error("ram read enable seen without spi_critical");

	// one record per deselect
	assert property (@(posedge clk) disable iff (reset)
		log_strobe |=> !log_strobe)
		else $error("log_strobe held longer than one cycle");

	// lock is gone once deselect on the pin has been seen
	assert property (@(posedge clk) disable iff (reset)
		$rose(cs_n) |-> ##release_cycles !spi_critical)
		else $error("spi_critical still high after deselect");

	// error flags only clear through reset
	assert property (@(posedge clk) disable iff (reset)
		(($past(errors) & ~errors) == 8'h00))
		else $error("sticky error flag cleared without reset");
endmodule

bind flash_emulator flash_tb_assert u_assert (
	.clk(clk),
	.reset(reset),
	.ram_read_enable(ram_read_enable),
	.spi_critical(spi_critical),
	.log_strobe(log_strobe),
	.cs_n(cs_n),
	.errors(errors)
);

`default_nettype wire

/* logic/flash_emulator.sv */
// spi flash emulator top
`timescale 1ns/1ps
`default_nettype none

module flash_emulator
	import flash_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// spi pins, mode 0
	input wire logic cs_n,
	input wire logic sclk,
	input wire logic mosi,
	output logic miso,

	// ram read port
	output ram_addr_t ram_addr,
	output logic ram_read_enable,
	input wire spi_byte_t ram_read_data,
	input wire logic ram_read_valid,

	// bus lock request
	output logic spi_critical,

	// read log
	output flash_addr_t log_addr,
	output log_len_t log_len,
	output logic log_strobe,

	output flash_err_t errors
);
	// serial port to decoder
	spi_byte_t rx_data;
	logic rx_cmd;
	logic rx_strobe;
	logic cs_rise;

	// engine back to serial port
	logic tx_strobe;
	spi_byte_t tx_data;

	// decode events
	logic read_start;
	logic prime;
	logic addr_lo_done;
	logic data_byte;
	logic bad_opcode;
	flash_addr_t start_addr;

	spi_byte_port u_port (
		.clk(clk), .reset(reset),
		.cs_n(cs_n), .sclk(sclk), .mosi(mosi), .miso(miso),
		.tx_strobe(tx_strobe), .tx_data(tx_data),
		.rx_data(rx_data), .rx_cmd(rx_cmd), .rx_strobe(rx_strobe), .cs_rise(cs_rise)
	);

	flash_cmd_decode u_decode (
		.clk(clk), .reset(reset),
		.rx_data(rx_data), .rx_cmd(rx_cmd), .rx_strobe(rx_strobe), .cs_rise(cs_rise),
		.read_start(read_start), .prime(prime), .addr_lo_done(addr_lo_done),
		.data_byte(data_byte), .bad_opcode(bad_opcode), .start_addr(start_addr)
	);

	flash_read_engine u_engine (
		.clk(clk), .reset(reset),
		.read_start(read_start), .prime(prime), .addr_lo_done(addr_lo_done),
		.data_byte(data_byte), .cs_rise(cs_rise), .bad_opcode(bad_opcode),
		.start_addr(start_addr),
		.ram_addr(ram_addr), .ram_read_enable(ram_read_enable),
		.spi_critical(spi_critical),
		.ram_read_data(ram_read_data), .ram_read_valid(ram_read_valid),
		.tx_strobe(tx_strobe), .tx_data(tx_data), .errors(errors)
	);

	flash_access_log u_log (
		.clk(clk), .reset(reset),
		.addr_lo_done(addr_lo_done), .data_byte(data_byte), .cs_rise(cs_rise),
		.start_addr(start_addr),
		.log_addr(log_addr), .log_len(log_len), .log_strobe(log_strobe)
	);
endmodule

`default_nettype wire

/* logic/flash_access_log.sv */
// flash read access log
`timescale 1ns/1ps
`default_nettype none

module flash_access_log
	import flash_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	input wire logic addr_lo_done,
	input wire logic data_byte,
	input wire logic cs_rise,
	input wire flash_addr_t start_addr,

	// record of the last read, held until the next one
	output flash_addr_t log_addr,
	output log_len_t log_len,
	output logic log_strobe
);
	// read has clocked at least one data slot
	logic in_data;

	always_ff @(posedge clk)
	begin
		log_strobe <= 1'b0;

		if (reset)
		begin
			in_data <= 1'b0;
			log_len <= '0;
		end
		else if (cs_rise)
		begin
			// only reads that reached the data phase are logged
			log_strobe <= in_data;
			in_data <= 1'b0;
		end
		else if (addr_lo_done)
		begin
			// new read, start a fresh record
			log_len <= '0;
			in_data <= 1'b0;
		end
		else if (data_byte)
		begin
			log_len <= log_len + log_len_t'(1);
			in_data <= 1'b1;
		end
	end

	// start address stays put while the count runs
	always_ff @(posedge clk)
	begin
		if (addr_lo_done)
			log_addr <= start_addr;
	end
endmodule

`default_nettype wire

/* logic/flash_read_engine.sv */
// flash read engine
`timescale 1ns/1ps
`default_nettype none

`include "flash_settings.svh"

module flash_read_engine
	import flash_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// decode events
	input wire logic read_start,
	input wire logic prime,
	input wire logic addr_lo_done,
	input wire logic data_byte,
	input wire logic cs_rise,
	input wire logic bad_opcode,
	input wire flash_addr_t start_addr,

	// ram read port
	output ram_addr_t ram_addr,
	output logic ram_read_enable,
	output logic spi_critical,
	input wire spi_byte_t ram_read_data,
	input wire logic ram_read_valid,

	// transmit byte to the serial port
	output logic tx_strobe,
	output spi_byte_t tx_data,

	output flash_err_t errors
);
	// set once real data reads start, prime data is dropped
	logic streaming;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			spi_critical <= 1'b0;
			ram_read_enable <= 1'b0;
			streaming <= 1'b0;
			tx_strobe <= 1'b0;
			errors <= '0;
		end
		else
		begin
			tx_strobe <= ram_read_valid && streaming;

			// sticky until reset
			if (bad_opcode)
				errors[err_bad_opcode_bit] <= 1'b1;

			if (cs_rise)
			begin
				// release the bus lock on deselect
				spi_critical <= 1'b0;
				ram_read_enable <= 1'b0;
				streaming <= 1'b0;
			end
			else if (read_start)
				spi_critical <= 1'b1;
			else if (spi_critical && prime)
				ram_read_enable <= 1'b1;
			else if (spi_critical && addr_lo_done)
			begin
				ram_read_enable <= 1'b1;
				streaming <= 1'b1;
			end
			else if (spi_critical && data_byte)
			begin
				// previous read still open means its slot was missed
				if (ram_read_enable)
					errors[err_overrun_bit] <= 1'b1;
				ram_read_enable <= 1'b1;
			end
			else if (ram_read_valid)
				ram_read_enable <= 1'b0;
		end
	end

	// address and data path
	always_ff @(posedge clk)
	begin
		// partial address, low byte not known yet
		if (prime)
			ram_addr <= ram_addr_t'({start_addr[`FLASH_ADDR_BITS-1:8], 8'h00});
		else if (addr_lo_done)
			ram_addr <= ram_addr_t'(start_addr);
		else if (data_byte)
			ram_addr <= ram_addr + ram_addr_t'(1);
		tx_data <= ram_read_data;
	end
endmodule

`default_nettype wire

/* logic/flash_cmd_decode.sv */
// flash command decoder
`timescale 1ns/1ps
`default_nettype none

`include "flash_settings.svh"

module flash_cmd_decode
	import flash_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// bytes from the serial port
	input wire spi_byte_t rx_data,
	input wire logic rx_cmd,
	input wire logic rx_strobe,
	input wire logic cs_rise,

	// decode events, one cycle after the strobes
	output logic read_start,
	output logic prime,
	output logic addr_lo_done,
	output logic data_byte,
	output logic bad_opcode,
	output flash_addr_t start_addr
);
	decode_state_t state;

	always_ff @(posedge clk)
	begin
		// all decode outputs are single cycle pulses
		read_start <= 1'b0;
		prime <= 1'b0;
		addr_lo_done <= 1'b0;
		data_byte <= 1'b0;
		bad_opcode <= 1'b0;

		if (reset)
			state <= idle;
		else if (cs_rise)
			state <= idle;
		else if (rx_cmd)
		begin
			// a new transaction always starts over
			if (rx_data == `FLASH_OP_READ)
			begin
				read_start <= 1'b1;
				state <= opcode_done;
			end
			else
			begin
				bad_opcode <= 1'b1;
				state <= ignore;
			end
		end
		else if (rx_strobe)
		begin
			case (state)
				opcode_done:
					state <= addr_hi;
				addr_hi:
				begin
					// upper two bytes are enough to open the ram row
					prime <= 1'b1;
					state <= addr_mid;
				end
				addr_mid:
				begin
					addr_lo_done <= 1'b1;
					state <= addr_lo;
				end
				addr_lo, data:
				begin
					// every byte after the address is a data slot
					data_byte <= 1'b1;
					state <= data;
				end
				default:
					// idle or ignore, wait for deselect
					state <= state;
			endcase
		end
	end

	// address bytes arrive high first
	always_ff @(posedge clk)
	begin
		if (rx_strobe && state == opcode_done)
			start_addr[`FLASH_ADDR_BITS-1:16] <= rx_data;
		if (rx_strobe && state == addr_hi)
			start_addr[15:8] <= rx_data;
		if (rx_strobe && state == addr_mid)
			start_addr[7:0] <= rx_data;
	end
endmodule

`default_nettype wire

/* logic/spi_byte_port.sv */
// spi serial byte port
`timescale 1ns/1ps
`default_nettype none

`include "flash_settings.svh"

module spi_byte_port
	import flash_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// serial pins from the host
	input wire logic cs_n,
	input wire logic sclk,
	input wire logic mosi,
	output logic miso,

	// transmit byte from the read engine
	input wire logic tx_strobe,
	input wire spi_byte_t tx_data,

	// received bytes
	output spi_byte_t rx_data,
	output logic rx_cmd,
	output logic rx_strobe,
	output logic cs_rise
);
	localparam int stages = `FLASH_SYNC_STAGES;

	// synchronizer chains, oldest sample at the top
	logic [stages-1:0] sclk_sync;
	logic [stages-1:0] cs_sync;
	logic [stages-1:0] mosi_sync;

	logic sclk_prev;
	logic cs_prev;
	logic [2:0] bit_cnt;
	logic first_byte;
	logic [1:0] done_pipe;
	spi_byte_t rx_shift;
	spi_byte_t tx_hold;
	logic tx_pending;
	spi_byte_t tx_shift;

	logic sclk_s;
	logic cs_s;
	logic mosi_s;
	logic sclk_rise;
	logic sclk_fall;
	logic boundary;

	assign sclk_s = sclk_sync[stages-1];
	assign cs_s = cs_sync[stages-1];
	assign mosi_s = mosi_sync[stages-1];

	// edges only count while selected
	assign sclk_rise = sclk_s && !sclk_prev && !cs_s;
	assign sclk_fall = !sclk_s && sclk_prev && !cs_s;

	// first falling edge after a full byte starts the next byte slot
	assign boundary = sclk_fall && bit_cnt == 3'd0;

	// mode 0, msb first
	assign miso = tx_shift[7];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sclk_sync <= '0;
			cs_sync <= '1;
			sclk_prev <= 1'b0;
			cs_prev <= 1'b1;
			bit_cnt <= 3'd0;
			first_byte <= 1'b0;
			done_pipe <= 2'b00;
			rx_cmd <= 1'b0;
			rx_strobe <= 1'b0;
			cs_rise <= 1'b0;
			tx_pending <= 1'b0;
			tx_shift <= '0;
		end
		else
		begin
			sclk_sync <= {sclk_sync[stages-2:0], sclk};
			cs_sync <= {cs_sync[stages-2:0], cs_n};
			sclk_prev <= sclk_s;
			cs_prev <= cs_s;
			cs_rise <= cs_s && !cs_prev;

			// framing restarts at every select
			if (cs_s)
				bit_cnt <= 3'd0;
			else if (sclk_rise)
				bit_cnt <= bit_cnt + 3'd1;

			if (!cs_s && cs_prev)
				first_byte <= 1'b1;
			else if (done_pipe[1])
				first_byte <= 1'b0;

			// eighth bit seen, strobe 3 cycles later
			done_pipe <= {done_pipe[0], sclk_rise && bit_cnt == 3'd7};
			rx_cmd <= done_pipe[1] && first_byte;
			rx_strobe <= done_pipe[1] && !first_byte;

			// late byte leaves the old contents rotating out
			if (boundary && tx_strobe)
				tx_shift <= tx_data;
			else if (boundary && tx_pending)
				tx_shift <= tx_hold;
			else if (sclk_fall)
				tx_shift <= {tx_shift[6:0], tx_shift[7]};

			if (cs_s)
				tx_pending <= 1'b0;
			else if (tx_strobe && !boundary)
				tx_pending <= 1'b1;
			else if (boundary)
				tx_pending <= 1'b0;
		end
	end

	// data path
	always_ff @(posedge clk)
	begin
		mosi_sync <= {mosi_sync[stages-2:0], mosi};
		if (sclk_rise)
			rx_shift <= {rx_shift[6:0], mosi_s};
		if (done_pipe[0])
			rx_data <= rx_shift;
		if (tx_strobe)
			tx_hold <= tx_data;
	end
endmodule

`default_nettype wire

/* logic/flash_pkg.sv */
// flash emulator types
`default_nettype none

`include "flash_settings.svh"

package flash_pkg;

	// one serial byte or one ram data byte
	typedef logic [7:0] spi_byte_t;

	// flash side address
	typedef logic [`FLASH_ADDR_BITS-1:0] flash_addr_t;

	// ram side address
	typedef logic [`FLASH_RAM_ADDR_BITS-1:0] ram_addr_t;

	// data bytes in one read, wraps
	typedef logic [7:0] log_len_t;

	// sticky error flags
	typedef logic [7:0] flash_err_t;

	// error bit positions
	localparam int err_bad_opcode_bit = 0;
	localparam int err_overrun_bit = 1;

	// command decode progress, named for the last completed byte
	typedef enum logic [2:0] {
		idle,
		opcode_done,
		addr_hi,
		addr_mid,
		addr_lo,
		data,
		ignore
	} decode_state_t;

endpackage

`default_nettype wire

/* logic/flash_settings.svh */
// flash emulator settings
`ifndef FLASH_SETTINGS_SVH
`define FLASH_SETTINGS_SVH

// flash address width, 3 address bytes
`define FLASH_ADDR_BITS 24

// width of the ram address port
// flash address is zero extended into it
`define FLASH_RAM_ADDR_BITS 32

// the only supported command
`define FLASH_OP_READ 8'h03

// flops in front of each serial input
`define FLASH_SYNC_STAGES 2

`endif
